// ==== Makefile ====
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module controlUnitTb

sim:
	verilator --binary --timing --assert -f vlog.f --top-module controlUnitTb -o controlUnitTb
	./obj_dir/controlUnitTb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/branchResolver.sv ====
`timescale 1ns/1ps

module branchResolver (
  input  logic clk,
  input  logic rstN,
  input  logic aluFlag,
  input  ctrlPkg::state_t state,
  input  isaPkg::instrClass_t instrClass,
  input  isaPkg::branchKind_t branchKind,
  output logic branchPending
);

  logic taken;

  always_comb begin
    case (instrClass)
      isaPkg::clsBranch: begin
        case (branchKind)
          isaPkg::brBeq, isaPkg::brBlez: taken = aluFlag;
          default: taken = !aluFlag;
        endcase
      end
      isaPkg::clsJump, isaPkg::clsJumpReg: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Last sample in sExec1 steers the next fetch
  always_ff @(posedge clk) begin
    if (!rstN) begin
      branchPending <= 1'b0;
    end else if (state == ctrlPkg::sExec1) begin
      branchPending <= taken;
    end
  end

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module controlUnit (
  input  logic clk,
  input  logic rstN,
  input  logic run,
  input  logic [`INSTR_WIDTH-1:0] instr,
  input  logic waitrequest,
  input  logic aluBusy,
  input  logic aluFlag,
  input  logic pcIsZero,
  output logic active,
  output logic pcWrite,
  output logic pcSrc,
  output logic irWrite,
  output logic iorD,
  output logic memRead,
  output logic memWrite,
  output logic [`BYTE_EN_WIDTH-1:0] byteEnable,
  output ctrlPkg::loadExt_t loadExtend,
  output logic regWrite,
  output logic regDst,
  output logic memToReg,
  output logic link,
  output logic aluSrcA,
  output ctrlPkg::srcB_t aluSrcB,
  output ctrlPkg::aluOp_t aluOp,
  output logic aluBypass,
  output logic extSel
);

  // Decoded instruction attributes
  isaPkg::instrClass_t instrClass;
  isaPkg::branchKind_t branchKind;
  logic [1:0] execStages;
  logic [`BYTE_EN_WIDTH-1:0] byteLanes;
  ctrlPkg::loadExt_t loadKind;
  logic immZeroExt;
  logic isLink;
  ctrlPkg::aluOp_t execOp;

  ctrlPkg::state_t state;
  logic branchPending;

  instrClassifier u_instrClassifier (.*);

  cycleSequencer u_cycleSequencer (.*);

  branchResolver u_branchResolver (.*);

  datapathControl u_datapathControl (.*);

endmodule

// ==== design/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Instruction word layout
`define INSTR_WIDTH 32
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6

// Memory lanes
`define BYTE_EN_WIDTH 4

// ALU control code
`define ALU_OP_WIDTH 5

`endif

// ==== design/ctrlPkg.sv ====
`include "cpu_settings.svh"

package ctrlPkg;

  typedef enum logic [2:0] {
    sHalted    = 3'd0,
    sFetch     = 3'd1,
    sFetchWait = 3'd2,
    sDecode    = 3'd3,
    sExec1     = 3'd4,
    sExec2     = 3'd5,
    sExec3     = 3'd6
  } state_t;

  // Codes understood by the existing ALU
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    opAnd        = 5'd0,
    opOr         = 5'd1,
    opAdd        = 5'd2,
    opXor        = 5'd3,
    opGtz        = 5'd7,
    opEq         = 5'd10,
    opPassB      = 5'd11,
    opLez        = 5'd12,
    opBranchAdd  = 5'd13,
    opPassA      = 5'd14,
    opFunct      = 5'd15,
    opJumpTarget = 5'd17,
    opUpper      = 5'd20
  } aluOp_t;

  typedef enum logic [1:0] {srcReg, srcFour, srcImm, srcImmShifted} srcB_t;

  typedef enum logic [1:0] {
    extZero       = 2'b00,
    extByteSigned = 2'b10,
    extHalfSigned = 2'b11
  } loadExt_t;

endpackage

// ==== design/cycleSequencer.sv ====
`timescale 1ns/1ps

module cycleSequencer (
  input  logic clk,
  input  logic rstN,
  input  logic run,
  input  logic waitrequest,
  input  logic aluBusy,
  input  logic pcIsZero,
  input  logic [1:0] execStages,
  input  isaPkg::instrClass_t instrClass,
  output ctrlPkg::state_t state,
  output logic active
);

  ctrlPkg::state_t nextState;
  logic memAccess;

  assign memAccess = (instrClass == isaPkg::clsLoad) || (instrClass == isaPkg::clsStore);
  assign active = (state != ctrlPkg::sHalted);

  always_comb begin
    nextState = state;
    case (state)
      ctrlPkg::sHalted: begin
        if (run) begin
          nextState = ctrlPkg::sFetch;
        end
      end
      ctrlPkg::sFetch, ctrlPkg::sFetchWait:
        nextState = waitrequest ? ctrlPkg::sFetchWait : ctrlPkg::sDecode;
      ctrlPkg::sDecode: nextState = ctrlPkg::sExec1;
      ctrlPkg::sExec1: begin
        if (!aluBusy) begin
          nextState = (execStages == 2'd1) ? ctrlPkg::sFetch : ctrlPkg::sExec2;
        end
      end
      ctrlPkg::sExec2: begin
        // Only a data access waits on memory here
        if (!(memAccess && waitrequest)) begin
          nextState = (execStages == 2'd2) ? ctrlPkg::sFetch : ctrlPkg::sExec3;
        end
      end
      ctrlPkg::sExec3: nextState = ctrlPkg::sFetch;
      default: nextState = ctrlPkg::sHalted;
    endcase
    // PC of zero ends the program
    if (active && pcIsZero) begin
      nextState = ctrlPkg::sHalted;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= ctrlPkg::sHalted;
    end else begin
      state <= nextState;
    end
  end

endmodule

// ==== design/datapathControl.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module datapathControl (
  input  ctrlPkg::state_t state,
  input  isaPkg::instrClass_t instrClass,
  input  logic [`BYTE_EN_WIDTH-1:0] byteLanes,
  input  ctrlPkg::loadExt_t loadKind,
  input  logic immZeroExt,
  input  logic isLink,
  input  logic branchPending,
  input  ctrlPkg::aluOp_t execOp,
  output logic pcWrite,
  output logic irWrite,
  output logic iorD,
  output logic memRead,
  output logic memWrite,
  output logic [`BYTE_EN_WIDTH-1:0] byteEnable,
  output ctrlPkg::loadExt_t loadExtend,
  output logic regWrite,
  output logic regDst,
  output logic memToReg,
  output logic link,
  output logic aluSrcA,
  output ctrlPkg::srcB_t aluSrcB,
  output ctrlPkg::aluOp_t aluOp,
  output logic aluBypass,
  output logic extSel,
  output logic pcSrc
);

  always_comb begin
    pcWrite = 1'b0;
    irWrite = 1'b0;
    iorD = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    byteEnable = '0;
    loadExtend = ctrlPkg::extZero;
    regWrite = 1'b0;
    regDst = 1'b0;
    memToReg = 1'b0;
    link = 1'b0;
    aluSrcA = 1'b0;
    aluSrcB = ctrlPkg::srcReg;
    aluOp = ctrlPkg::opAnd;
    aluBypass = 1'b0;
    extSel = 1'b0;
    pcSrc = 1'b0;
    case (state)
      ctrlPkg::sFetch: begin
        pcWrite = 1'b1;
        memRead = 1'b1;
        byteEnable = '1;
        pcSrc = branchPending;
        // PC + 4 unless a taken branch supplies the target
        aluSrcB = ctrlPkg::srcFour;
        aluOp = ctrlPkg::opAdd;
      end
      ctrlPkg::sFetchWait: begin
        memRead = 1'b1;
        byteEnable = '1;
      end
      ctrlPkg::sDecode: begin
        irWrite = 1'b1;
        aluSrcB = ctrlPkg::srcImmShifted;
        if (instrClass == isaPkg::clsJump) begin
          extSel = 1'b1;
          aluOp = ctrlPkg::opPassB;
        end else begin
          aluOp = ctrlPkg::opBranchAdd;
        end
      end
      ctrlPkg::sExec1: begin
        aluOp = execOp;
        case (instrClass)
          isaPkg::clsRAlu, isaPkg::clsJumpReg: aluSrcA = 1'b1;
          isaPkg::clsBranch: begin
            aluSrcA = 1'b1;
            aluBypass = 1'b1;
          end
          isaPkg::clsImmAlu, isaPkg::clsLoad, isaPkg::clsStore: begin
            aluSrcA = 1'b1;
            aluSrcB = ctrlPkg::srcImm;
            extSel = (instrClass == isaPkg::clsImmAlu) && immZeroExt;
          end
          isaPkg::clsJump: begin
            // JAL saves PC + 4, J builds the jump target
            extSel = 1'b1;
            link = isLink;
            aluSrcB = isLink ? ctrlPkg::srcFour : ctrlPkg::srcImmShifted;
          end
          default: aluOp = ctrlPkg::opAnd;
        endcase
      end
      ctrlPkg::sExec2: begin
        case (instrClass)
          isaPkg::clsRAlu, isaPkg::clsImmAlu: begin
            aluBypass = 1'b1;
            regWrite = 1'b1;
            regDst = (instrClass == isaPkg::clsRAlu);
            memToReg = 1'b1;
          end
          isaPkg::clsLoad: begin
            iorD = 1'b1;
            memRead = 1'b1;
            byteEnable = byteLanes;
            loadExtend = loadKind;
            aluBypass = 1'b1;
          end
          isaPkg::clsStore: begin
            iorD = 1'b1;
            memWrite = 1'b1;
            byteEnable = '1;
          end
          default: regWrite = 1'b0;
        endcase
      end
      // Load writeback from the data register
      ctrlPkg::sExec3: regWrite = (instrClass == isaPkg::clsLoad);
      default: pcWrite = 1'b0;
    endcase
  end

endmodule

// ==== design/instrClassifier.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instrClassifier (
  input  logic [`INSTR_WIDTH-1:0] instr,
  output isaPkg::instrClass_t instrClass,
  output isaPkg::branchKind_t branchKind,
  output logic [1:0] execStages,
  output logic [`BYTE_EN_WIDTH-1:0] byteLanes,
  output ctrlPkg::loadExt_t loadKind,
  output logic immZeroExt,
  output logic isLink,
  output ctrlPkg::aluOp_t execOp
);

  logic [`OPCODE_WIDTH-1:0] opcode;
  logic [`FUNCT_WIDTH-1:0] funct;

  assign opcode = instr[`INSTR_WIDTH-1 -: `OPCODE_WIDTH];
  assign funct = instr[`FUNCT_WIDTH-1:0];

  always_comb begin
    instrClass = isaPkg::clsIllegal;
    branchKind = isaPkg::branchKind_t'(opcode[1:0]);
    byteLanes = '0;
    loadKind = ctrlPkg::extZero;
    immZeroExt = 1'b0;
    isLink = 1'b0;
    execOp = ctrlPkg::opAdd;
    case (opcode)
      isaPkg::ocSpecial: begin
        case (funct)
          isaPkg::fnAddu, isaPkg::fnAnd, isaPkg::fnOr: begin
            instrClass = isaPkg::clsRAlu;
            execOp = ctrlPkg::opFunct;
          end
          isaPkg::fnJr: begin
            instrClass = isaPkg::clsJumpReg;
            execOp = ctrlPkg::opPassA;
          end
          default: instrClass = isaPkg::clsIllegal;
        endcase
      end
      isaPkg::ocAddiu: instrClass = isaPkg::clsImmAlu;
      isaPkg::ocAndi: begin
        instrClass = isaPkg::clsImmAlu;
        immZeroExt = 1'b1;
        execOp = ctrlPkg::opAnd;
      end
      isaPkg::ocOri: begin
        instrClass = isaPkg::clsImmAlu;
        immZeroExt = 1'b1;
        execOp = ctrlPkg::opOr;
      end
      isaPkg::ocXori: begin
        instrClass = isaPkg::clsImmAlu;
        immZeroExt = 1'b1;
        execOp = ctrlPkg::opXor;
      end
      isaPkg::ocLui: begin
        instrClass = isaPkg::clsImmAlu;
        execOp = ctrlPkg::opUpper;
      end
      isaPkg::ocLw, isaPkg::ocLh, isaPkg::ocLhu, isaPkg::ocLb, isaPkg::ocLbu: begin
        instrClass = isaPkg::clsLoad;
        // Access width sits in the low opcode bits, bit 2 marks unsigned
        byteLanes = (opcode[1:0] == 2'b00) ? 4'b0001 :
                    (opcode[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        if (!opcode[2] && !opcode[1]) begin
          loadKind = opcode[0] ? ctrlPkg::extHalfSigned : ctrlPkg::extByteSigned;
        end
      end
      isaPkg::ocSw: instrClass = isaPkg::clsStore;
      isaPkg::ocBeq, isaPkg::ocBne, isaPkg::ocBlez, isaPkg::ocBgtz: begin
        instrClass = isaPkg::clsBranch;
        execOp = !opcode[1] ? ctrlPkg::opEq :
                 opcode[0] ? ctrlPkg::opGtz : ctrlPkg::opLez;
      end
      isaPkg::ocJ: begin
        instrClass = isaPkg::clsJump;
        execOp = ctrlPkg::opJumpTarget;
      end
      isaPkg::ocJal: begin
        instrClass = isaPkg::clsJump;
        isLink = 1'b1;
      end
      default: instrClass = isaPkg::clsIllegal;
    endcase
  end

  always_comb begin
    case (instrClass)
      isaPkg::clsLoad: execStages = 2'd3;
      isaPkg::clsRAlu, isaPkg::clsImmAlu, isaPkg::clsStore: execStages = 2'd2;
      // Branches, jumps and the idle stage of an illegal word
      default: execStages = 2'd1;
    endcase
  end

endmodule

// ==== design/isaPkg.sv ====
`include "cpu_settings.svh"

package isaPkg;

  // Primary opcodes of the kept instructions
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    ocSpecial = 6'b000000,
    ocJ       = 6'b000010,
    ocJal     = 6'b000011,
    ocBeq     = 6'b000100,
    ocBne     = 6'b000101,
    ocBlez    = 6'b000110,
    ocBgtz    = 6'b000111,
    ocAddiu   = 6'b001001,
    ocAndi    = 6'b001100,
    ocOri     = 6'b001101,
    ocXori    = 6'b001110,
    ocLui     = 6'b001111,
    ocLb      = 6'b100000,
    ocLh      = 6'b100001,
    ocLw      = 6'b100011,
    ocLbu     = 6'b100100,
    ocLhu     = 6'b100101,
    ocSw      = 6'b101011
  } opcode_t;

  typedef enum logic [`FUNCT_WIDTH-1:0] {
    fnJr   = 6'b001000,
    fnAddu = 6'b100001,
    fnAnd  = 6'b100100,
    fnOr   = 6'b100101
  } funct_t;

  typedef enum logic [2:0] {
    clsRAlu, clsJumpReg, clsImmAlu, clsLoad,
    clsStore, clsBranch, clsJump, clsIllegal
  } instrClass_t;

  // Ordered like the low two bits of the branch opcodes
  typedef enum logic [1:0] {brBeq, brBne, brBlez, brBgtz} branchKind_t;

endpackage

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module controlUnitTb;

  logic clk = 1'b0;
  logic rstN;
  logic run;
  logic [`INSTR_WIDTH-1:0] instr;
  logic waitrequest;
  logic aluBusy;
  logic aluFlag;
  logic pcIsZero;
  logic active, pcWrite, pcSrc, irWrite, iorD, memRead, memWrite;
  logic [`BYTE_EN_WIDTH-1:0] byteEnable;
  ctrlPkg::loadExt_t loadExtend;
  logic regWrite, regDst, memToReg, link, aluSrcA;
  ctrlPkg::srcB_t aluSrcB;
  ctrlPkg::aluOp_t aluOp;
  logic aluBypass, extSel;

  int errors = 0;
  int testsRun = 0;
  int testErrors;
  string testName;

  // What one instruction showed between two fetches
  int cycleIdx, pcWrites, irWrites, fetchReads, fetchReadsAtIr;
  int dataReads, memWrites, regWrites, regWriteCycle, lastDataCycle, links;
  logic [`BYTE_EN_WIDTH-1:0] dataBe;
  logic [`BYTE_EN_WIDTH-1:0] storeBe;
  ctrlPkg::loadExt_t dataExt;
  logic wbMemToReg, wbRegDst, execExtSel, afterDecode, nextPcSrc;
  ctrlPkg::aluOp_t execAluOp;
  ctrlPkg::srcB_t execSrcB;
  logic execSrcA, execBypass;
  int fetchLeft, dataLeft, busyLeft;

  controlUnit u_controlUnit (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] immWord(input isaPkg::opcode_t opcode);
    return {opcode, 5'($urandom), 5'($urandom), 16'($urandom)};
  endfunction

  function automatic logic [31:0] regWord(input isaPkg::funct_t funct);
    return {isaPkg::ocSpecial, 5'($urandom), 5'($urandom), 5'($urandom), 5'd0, funct};
  endfunction

  function automatic logic [31:0] jumpWord(input isaPkg::opcode_t opcode);
    return {opcode, 26'($urandom)};
  endfunction

  // Load width table
  function automatic logic [`BYTE_EN_WIDTH-1:0] expectedLanes(input isaPkg::opcode_t opcode);
    case (opcode)
      isaPkg::ocLb, isaPkg::ocLbu: return 4'b0001;
      isaPkg::ocLh, isaPkg::ocLhu: return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic ctrlPkg::loadExt_t expectedExt(input isaPkg::opcode_t opcode);
    case (opcode)
      isaPkg::ocLb: return ctrlPkg::extByteSigned;
      isaPkg::ocLh: return ctrlPkg::extHalfSigned;
      default: return ctrlPkg::extZero;
    endcase
  endfunction

  task automatic reportMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
    $display("[ERROR] %s %s: got 0x%0h, expected 0x%0h", testName, what, got, expected);
    errors++;
  endtask

  // ALU selects seen in the first execute cycle
  task automatic checkExecSelects(input ctrlPkg::aluOp_t expOp, input logic expSrcA,
                                  input ctrlPkg::srcB_t expSrcB, input logic expBypass);
    if (execAluOp !== expOp) reportMismatch("aluOp", 32'(execAluOp), 32'(expOp));
    if (execSrcA !== expSrcA) reportMismatch("aluSrcA", 32'(execSrcA), 32'(expSrcA));
    if (execSrcB !== expSrcB) reportMismatch("aluSrcB", 32'(execSrcB), 32'(expSrcB));
    if (execBypass !== expBypass) begin
      reportMismatch("aluBypass", 32'(execBypass), 32'(expBypass));
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErrors = errors;
  endtask

  task automatic finishTest();
    testsRun++;
    $display("%-12s done, %0d mismatches", testName, errors - testErrors);
  endtask

  // Record the current cycle, then set the handshake for the next edge
  task automatic sampleAndDrive(input int busy);
    if (pcWrite) pcWrites++;
    if (memRead && !iorD) begin
      fetchReads++;
      if (byteEnable != '1) reportMismatch("fetch byteEnable", 32'(byteEnable), 32'hf);
    end
    if (memRead && iorD) begin
      dataReads++;
      dataBe = byteEnable;
      dataExt = loadExtend;
      lastDataCycle = cycleIdx;
    end
    if (memWrite) begin
      memWrites++;
      storeBe = byteEnable;
    end
    if (!memRead && !memWrite && byteEnable != '0) begin
      reportMismatch("idle byteEnable", 32'(byteEnable), 0);
    end
    if (irWrite) begin
      irWrites++;
      fetchReadsAtIr = fetchReads;
    end
    if (regWrite) begin
      regWrites++;
      regWriteCycle = cycleIdx;
      wbMemToReg = memToReg;
      wbRegDst = regDst;
    end
    if (link) links++;
    if (afterDecode) begin
      execExtSel = extSel;
      execAluOp = aluOp;
      execSrcA = aluSrcA;
      execSrcB = aluSrcB;
      execBypass = aluBypass;
    end
    afterDecode = irWrite;
    cycleIdx++;
    waitrequest = 1'b0;
    if (memRead || memWrite) begin
      if (iorD && dataLeft > 0) begin
        waitrequest = 1'b1;
        dataLeft--;
      end else if (!iorD && fetchLeft > 0) begin
        waitrequest = 1'b1;
        fetchLeft--;
      end
    end
    // Busy covers the first busy edges of sExec1
    if (irWrite) busyLeft = busy + 1;
    else if (busyLeft > 0) busyLeft--;
    aluBusy = (busyLeft > 0);
  endtask

  // Starts at a falling edge inside sFetch, ends at the next one
  task automatic execute(input logic [31:0] word, input int busy, input int fetchWait,
                         input int dataWait);
    int guard;
    cycleIdx = 0;
    pcWrites = 0;
    irWrites = 0;
    fetchReads = 0;
    fetchReadsAtIr = 0;
    dataReads = 0;
    memWrites = 0;
    regWrites = 0;
    regWriteCycle = -1;
    lastDataCycle = -1;
    links = 0;
    fetchLeft = fetchWait;
    dataLeft = dataWait;
    busyLeft = 0;
    afterDecode = 1'b0;
    sampleAndDrive(busy);
    instr = word;
    guard = 0;
    @(negedge clk);
    while (!pcWrite && guard < 60) begin
      sampleAndDrive(busy);
      @(negedge clk);
      guard++;
    end
    nextPcSrc = pcSrc;
    if (!pcWrite) begin
      $display("Timeout: %s never reached the next fetch", testName);
      errors++;
    end
    if (pcWrites != 1) reportMismatch("pcWrite count", pcWrites, 1);
    if (irWrites != 1) reportMismatch("irWrite count", irWrites, 1);
  endtask

  task automatic testResetStart();
    int guard;
    startTest("resetStart");
    if (active !== 1'b0) reportMismatch("active", 32'(active), 0);
    if ({pcWrite, irWrite, memRead, memWrite, regWrite, link} !== 6'b0) begin
      reportMismatch("strobes", 32'({pcWrite, irWrite, memRead, memWrite, regWrite, link}), 0);
    end
    run = 1'b1;
    guard = 0;
    @(negedge clk);
    while (!active && guard < 10) begin
      @(negedge clk);
      guard++;
    end
    run = 1'b0;
    if (!active) begin
      $display("Timeout: active never rose after run");
      errors++;
    end
    if (pcWrite !== 1'b1) reportMismatch("pcWrite", 32'(pcWrite), 1);
    if (memRead !== 1'b1) reportMismatch("memRead", 32'(memRead), 1);
    if (byteEnable !== 4'hf) reportMismatch("byteEnable", 32'(byteEnable), 32'hf);
    execute(regWord(isaPkg::fnAddu), 0, 0, 0);
    finishTest();
  endtask

  task automatic testFetchWait();
    startTest("fetchWait");
    execute(regWord(isaPkg::fnOr), 0, 3, 0);
    if (fetchReads != 4) reportMismatch("fetch memRead cycles", fetchReads, 4);
    if (fetchReadsAtIr != 4) reportMismatch("memRead cycles before irWrite", fetchReadsAtIr, 4);
    finishTest();
  endtask

  task automatic checkAlu(input string name, input logic [31:0] word, input logic expDst,
                          input logic expZero, input ctrlPkg::aluOp_t expOp, input int busy);
    startTest(name);
    execute(word, busy, 0, 0);
    if (regWrites != 1) reportMismatch("regWrite count", regWrites, 1);
    if (wbMemToReg !== 1'b1) reportMismatch("memToReg", 32'(wbMemToReg), 1);
    if (wbRegDst !== expDst) reportMismatch("regDst", 32'(wbRegDst), 32'(expDst));
    if (execExtSel !== expZero) reportMismatch("extSel", 32'(execExtSel), 32'(expZero));
    if (regWriteCycle != 3 + busy) reportMismatch("regWrite cycle", regWriteCycle, 3 + busy);
    if (dataReads + memWrites != 0) reportMismatch("data access count", dataReads + memWrites, 0);
    // Register operand for R-type, immediate otherwise
    checkExecSelects(expOp, 1'b1, expDst ? ctrlPkg::srcReg : ctrlPkg::srcImm, 1'b0);
    finishTest();
  endtask

  task automatic checkLoad(input string name, input isaPkg::opcode_t opcode);
    startTest(name);
    execute(immWord(opcode), 0, 0, 2);
    if (dataReads != 3) reportMismatch("data memRead cycles", dataReads, 3);
    if (dataBe !== expectedLanes(opcode)) begin
      reportMismatch("byteEnable", 32'(dataBe), 32'(expectedLanes(opcode)));
    end
    if (dataExt !== expectedExt(opcode)) begin
      reportMismatch("loadExtend", 32'(dataExt), 32'(expectedExt(opcode)));
    end
    if (regWrites != 1) reportMismatch("regWrite count", regWrites, 1);
    if (wbMemToReg !== 1'b0) reportMismatch("memToReg", 32'(wbMemToReg), 0);
    if (regWriteCycle != lastDataCycle + 1) begin
      reportMismatch("regWrite cycle", regWriteCycle, lastDataCycle + 1);
    end
    checkExecSelects(ctrlPkg::opAdd, 1'b1, ctrlPkg::srcImm, 1'b0);
    finishTest();
  endtask

  task automatic testStore();
    startTest("sw");
    execute(immWord(isaPkg::ocSw), 0, 0, 0);
    if (memWrites != 1) reportMismatch("memWrite count", memWrites, 1);
    if (storeBe !== 4'hf) reportMismatch("byteEnable", 32'(storeBe), 32'hf);
    if (regWrites != 0) reportMismatch("regWrite count", regWrites, 0);
    if (dataReads != 0) reportMismatch("data memRead count", dataReads, 0);
    checkExecSelects(ctrlPkg::opAdd, 1'b1, ctrlPkg::srcImm, 1'b0);
    finishTest();
  endtask

  task automatic testBranches();
    isaPkg::opcode_t kinds[4];
    ctrlPkg::aluOp_t kindOps[4];
    int k;
    int flag;
    logic expTaken;
    kinds[0] = isaPkg::ocBeq;
    kinds[1] = isaPkg::ocBne;
    kinds[2] = isaPkg::ocBlez;
    kinds[3] = isaPkg::ocBgtz;
    kindOps[0] = ctrlPkg::opEq;
    kindOps[1] = ctrlPkg::opEq;
    kindOps[2] = ctrlPkg::opLez;
    kindOps[3] = ctrlPkg::opGtz;
    startTest("branches");
    for (k = 0; k < 4; k++) begin
      for (flag = 0; flag < 2; flag++) begin
        aluFlag = flag[0];
        execute(immWord(kinds[k]), 0, 0, 0);
        // BEQ and BLEZ take on a set flag, BNE and BGTZ on a clear one
        if (kinds[k] == isaPkg::ocBeq || kinds[k] == isaPkg::ocBlez) expTaken = flag[0];
        else expTaken = !flag[0];
        if (nextPcSrc !== expTaken) reportMismatch("pcSrc", 32'(nextPcSrc), 32'(expTaken));
        if (regWrites + links != 0) reportMismatch("regWrite and link count", regWrites + links, 0);
        checkExecSelects(kindOps[k], 1'b1, ctrlPkg::srcReg, 1'b1);
      end
    end
    aluFlag = 1'b0;
    finishTest();
  endtask

  task automatic testJumps();
    startTest("jumps");
    execute(jumpWord(isaPkg::ocJ), 0, 0, 0);
    if (nextPcSrc !== 1'b1) reportMismatch("pcSrc after J", 32'(nextPcSrc), 1);
    if (links != 0) reportMismatch("link count for J", links, 0);
    checkExecSelects(ctrlPkg::opJumpTarget, 1'b0, ctrlPkg::srcImmShifted, 1'b0);
    execute(jumpWord(isaPkg::ocJal), 0, 0, 0);
    if (nextPcSrc !== 1'b1) reportMismatch("pcSrc after JAL", 32'(nextPcSrc), 1);
    if (links != 1) reportMismatch("link count for JAL", links, 1);
    checkExecSelects(ctrlPkg::opAdd, 1'b0, ctrlPkg::srcFour, 1'b0);
    execute(regWord(isaPkg::fnJr), 0, 0, 0);
    if (nextPcSrc !== 1'b1) reportMismatch("pcSrc after JR", 32'(nextPcSrc), 1);
    if (links != 0) reportMismatch("link count for JR", links, 0);
    checkExecSelects(ctrlPkg::opPassA, 1'b1, ctrlPkg::srcReg, 1'b0);
    execute(regWord(isaPkg::fnAddu), 0, 0, 0);
    if (nextPcSrc !== 1'b0) reportMismatch("pcSrc after ADDU", 32'(nextPcSrc), 0);
    finishTest();
  endtask

  task automatic testHalt();
    int point;
    int guard;
    startTest("halt");
    // Halt from sFetch, sDecode, sExec1 and sExec2 in turn
    for (point = 0; point < 4; point++) begin
      instr = regWord(isaPkg::fnAddu);
      repeat (point) @(negedge clk);
      pcIsZero = 1'b1;
      @(negedge clk);
      pcIsZero = 1'b0;
      if (active !== 1'b0) reportMismatch("active after pcIsZero", 32'(active), 0);
      repeat (3) begin
        @(negedge clk);
        if (active !== 1'b0) reportMismatch("active while halted", 32'(active), 0);
      end
      run = 1'b1;
      guard = 0;
      @(negedge clk);
      while (!pcWrite && guard < 10) begin
        @(negedge clk);
        guard++;
      end
      run = 1'b0;
      if (!pcWrite) begin
        $display("Timeout: no fetch after restart from halt point %0d", point);
        errors++;
      end
    end
    finishTest();
  endtask

  initial begin
    int seedDummy;
    seedDummy = $urandom(65575);
    rstN = 1'b0;
    run = 1'b0;
    instr = '0;
    waitrequest = 1'b0;
    aluBusy = 1'b0;
    aluFlag = 1'b0;
    pcIsZero = 1'b0;
    repeat (8) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    testResetStart();
    testFetchWait();
    checkAlu("addu", regWord(isaPkg::fnAddu), 1'b1, 1'b0, ctrlPkg::opFunct, 0);
    checkAlu("ori", immWord(isaPkg::ocOri), 1'b0, 1'b1, ctrlPkg::opOr, 0);
    checkAlu("lui", immWord(isaPkg::ocLui), 1'b0, 1'b0, ctrlPkg::opUpper, 0);
    checkAlu("addiu", immWord(isaPkg::ocAddiu), 1'b0, 1'b0, ctrlPkg::opAdd, 0);
    checkAlu("andi", immWord(isaPkg::ocAndi), 1'b0, 1'b1, ctrlPkg::opAnd, 0);
    checkAlu("xori", immWord(isaPkg::ocXori), 1'b0, 1'b1, ctrlPkg::opXor, 0);
    checkAlu("aluBusy", immWord(isaPkg::ocAddiu), 1'b0, 1'b0, ctrlPkg::opAdd, 3);
    checkLoad("lw", isaPkg::ocLw);
    checkLoad("lh", isaPkg::ocLh);
    checkLoad("lhu", isaPkg::ocLhu);
    checkLoad("lb", isaPkg::ocLb);
    checkLoad("lbu", isaPkg::ocLbu);
    testStore();
    testBranches();
    testJumps();
    testHalt();
    $display("Tests run: %0d, mismatches: %0d", testsRun, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verification/controlUnit_assertions.sv ====
`timescale 1ns/1ps

module controlUnitAssertions (
  input logic clk,
  input logic rstN,
  input logic active,
  input logic pcWrite,
  input logic irWrite,
  input logic memRead,
  input logic memWrite,
  input logic regWrite,
  input logic link
);

  logic anyStrobe;

  assign anyStrobe = pcWrite || irWrite || memRead || memWrite || regWrite || link;

  // One memory direction per cycle
  memExclusive: assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite))
    else $error("memRead and memWrite high in the same cycle");

  irRegExclusive: assert property (@(posedge clk) disable iff (!rstN) !(irWrite && regWrite))
    else $error("irWrite and regWrite high in the same cycle");

  // Quiet and halted right after a reset edge
  resetQuiet: assert property (@(posedge clk) !rstN |=> !anyStrobe && !active)
    else $error("strobe or active high in the cycle after reset");

endmodule

bind controlUnit controlUnitAssertions u_controlUnitAssertions (.*);

// ==== vlog.f ====
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/instrClassifier.sv
design/cycleSequencer.sv
design/branchResolver.sv
design/datapathControl.sv
design/controlUnit.sv
verification/controlUnit_assertions.sv
verification/controlUnitTb.sv
